// File: build.f
+incdir+test
hw/pitaya_pkg.sv
hw/sys_bus_mux.sv
hw/hk_regs.sv
hw/analog_io.sv
hw/pwm_cfg_regs.sv
hw/pwm_dac.sv
hw/pitaya_top.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# compile with Verilator and run the testbench; exit status tells pass or fail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "run.sh: simulation FAILED"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "run.sh: simulator exited with status $sim_status"
  exit 1
fi

echo "run.sh: simulation passed"
exit 0

// File: test/tb_model.svh
//////////////////////////////////////////////////
// model functions and the check task, included into tb_top
//////////////////////////////////////////////////
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// pins are negative slope offset binary: 0x1FFF is zero, 0x0000 is full scale up
function automatic logic [31:0] adc_expected(input logic [13:0] raw);
  int value;
  value = 8191 - int'(raw);
  return 32'(value);   // sign-extended bus word
endfunction

// inverse map, signed setpoint to pin code
function automatic logic [13:0] dac_code(input int value);
  return 14'(8191 - value);
endfunction

// high cycles over 16 periods, one dither bit per period
function automatic int pwm_high_count(input logic [23:0] cfg, input int period);
  int total;
  int len;
  int j;
  total = 0;
  for (j = 0; j < 16; j++)
  begin
    len = int'(cfg[23:16]) + int'(cfg[j]);
    if (len > period)
      len = period;   // clipped to full period
    total += len;
  end
  return total;
endfunction

// region field, addr[22:20]
function automatic int region_of(input logic [31:0] addr);
  return int'(addr[22:20]);
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("FAILED %s expected %h actual %h", name, expected, actual);
    $display("Done: errors found");
    $fatal(1, "value mismatch in %s", name);
  end
endtask

`endif

// File: test/tb_top.sv
//////////////////////////////////////////////////
// one bus request at a time and inputs move 1 ns after the edge
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_top;

  localparam int NUM_PWM    = 4;
  localparam int PWM_PERIOD = 156;
  localparam int ACK_LIMIT  = 8;      // cycles before a bus access gives up
  localparam int N_RAND     = 8;      // random draws per test
  localparam int BUS_CYCLES = 2000;   // generous bound for tests 1 to 4
  localparam int PWM_CYCLES = 2 * 16 * PWM_PERIOD * NUM_PWM;
  localparam int TIMEOUT_NS = (BUS_CYCLES + PWM_CYCLES) * 12 / 10 * 10;
  localparam logic [31:0] PWM_BASE = 32'h0040_0000;   // region 4

  logic              adc_clk;
  logic              arst_n_i;
  logic [31:0]       sys_addr_i;
  logic [31:0]       sys_wdata_i;
  logic              sys_wen_i;
  logic              sys_ren_i;
  logic [31:0]       sys_rdata_o;
  logic              sys_ack_o;
  logic              sys_err_o;
  logic [13:0]       adc_dat_a_i;
  logic [13:0]       adc_dat_b_i;
  logic [13:0]       dac_dat_a_o;
  logic [13:0]       dac_dat_b_o;
  logic [7:0]        led_o;
  logic [NUM_PWM-1:0] dac_pwm_o;
  logic [31:0]       lcg_state = 32'h74bd;

  `include "tb_model.svh"

  pitaya_top #(
    .NUM_PWM    (NUM_PWM),
    .PWM_PERIOD (PWM_PERIOD)
  ) u_pitaya_top (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o),
    .dac_pwm_o   (dac_pwm_o)
  );

  always #5 adc_clk = ~adc_clk;   // 10 ns period

  // LCG step with the high half folded into the fast low bits
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // bus master

  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = write;
    sys_ren_i   = !write;
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;   // one cycle request
    sys_ren_i = 1'b0;
    waited    = 1;
    while (!sys_ack_o && waited < ACK_LIMIT)
    begin
      @(posedge adc_clk);
      #1;
      waited++;
    end
    if (!sys_ack_o)
    begin
      $display("bus: no ack for address %h within %0d cycles", addr, ACK_LIMIT);
      $display("Done: errors found");
      $fatal(1, "bus timeout");
    end
    check_value("ack_latency", 32'd1, 32'(waited));   // ack one cycle after request
    rdata = sys_rdata_o;
    err   = sys_err_o;
    @(posedge adc_clk);   // idle cycle so ack drops before next request
    #1;
    check_value("ack_pulse", 32'h0, 32'(sys_ack_o));
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused, err);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    bus_access(1'b0, addr, 32'h0, data, err);
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] wval;
    logic [31:0] addr;
    logic [13:0] raw_a;
    logic [13:0] raw_b;
    int          set_a;
    int          set_b;
    logic [23:0] cfg_words [NUM_PWM];
    int          high_cnt [NUM_PWM];
    adc_clk     = 1'b0;
    arst_n_i    = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    repeat (3) @(posedge adc_clk);
    #1;
    arst_n_i = 1'b1;
    wait_cycles(1);

    // after reset
    check_value("reset_dac_a", 32'h1FFF, 32'(dac_dat_a_o));
    check_value("reset_dac_b", 32'h1FFF, 32'(dac_dat_b_o));
    check_value("reset_led", 32'h0, 32'(led_o));
    check_value("reset_pwm", 32'h0, 32'(dac_pwm_o));
    bus_read(32'h00, rdata, err);
    check_value("hk_id", 32'h5049_0001, rdata);
    check_value("hk_id_err", 32'h0, 32'(err));

    // ADC conversion with pins held 3 cycles first
    repeat (N_RAND)
    begin
      wval        = next_rand();
      raw_a       = wval[13:0];
      raw_b       = wval[29:16];
      adc_dat_a_i = raw_a;
      adc_dat_b_i = raw_b;
      wait_cycles(3);
      bus_read(32'h14, rdata, err);
      check_value("adc_a", adc_expected(raw_a), rdata);
      check_value("adc_a_err", 32'h0, 32'(err));
      bus_read(32'h18, rdata, err);
      check_value("adc_b", adc_expected(raw_b), rdata);
    end

    // DAC pins and loopback
    bus_write(32'h04, 32'h1, err);
    repeat (N_RAND)
    begin
      wval  = next_rand();
      set_a = int'($signed(wval[13:0]));
      set_b = int'($signed(wval[29:16]));
      bus_write(32'h0C, 32'(set_a), err);
      check_value("dac_a_wr_err", 32'h0, 32'(err));
      bus_write(32'h10, 32'(set_b), err);
      check_value("dac_pin_a", 32'(dac_code(set_a)), 32'(dac_dat_a_o));
      check_value("dac_pin_b", 32'(dac_code(set_b)), 32'(dac_dat_b_o));
      bus_read(32'h14, rdata, err);
      check_value("loop_a", 32'(set_a), rdata);   // sign-extended setpoint
      bus_read(32'h18, rdata, err);
      check_value("loop_b", 32'(set_b), rdata);
      bus_read(32'h0C, rdata, err);
      check_value("dac_a_rd", 32'(set_a), rdata);
    end
    bus_write(32'h04, 32'h0, err);

    // bus decode
    for (int r = 0; r < 8; r++)
    begin
      addr = {9'h0, 3'(r), 20'h8};
      if (region_of(addr) != 0 && region_of(addr) != 4)
      begin
        bus_read(addr, rdata, err);
        check_value("unmapped_data", 32'h0, rdata);
        check_value("unmapped_err", 32'h0, 32'(err));
        bus_write(addr, next_rand(), err);
        check_value("unmapped_wr_err", 32'h0, 32'(err));
      end
    end
    bus_read(32'h1C, rdata, err);   // past last hk register
    check_value("hk_unknown_err", 32'h1, 32'(err));
    check_value("hk_unknown_data", 32'h0, rdata);
    bus_write(32'h14, 32'h0, err);
    check_value("hk_ro_adc_err", 32'h1, 32'(err));
    bus_write(32'h00, 32'h0, err);
    check_value("hk_ro_id_err", 32'h1, 32'(err));
    bus_read(32'h00, rdata, err);
    check_value("hk_id_kept", 32'h5049_0001, rdata);
    bus_read(PWM_BASE + 32'(4 * NUM_PWM), rdata, err);
    check_value("pwm_unknown_err", 32'h1, 32'(err));
    wval = next_rand();
    bus_write(32'h08, wval, err);
    bus_read(32'h08, rdata, err);
    check_value("led_rd", {24'h0, wval[7:0]}, rdata);
    check_value("led_pin", {24'h0, wval[7:0]}, 32'(led_o));
    for (int k = 0; k < NUM_PWM; k++)
    begin
      wval = next_rand();
      bus_write(PWM_BASE + 32'(4 * k), wval, err);
      bus_read(PWM_BASE + 32'(4 * k), rdata, err);
      check_value("pwm_cfg_rd", {8'h0, wval[23:0]}, rdata);   // top byte dropped
      check_value("pwm_cfg_err", 32'h0, 32'(err));
    end

    // PWM high counts
    for (int k = 0; k < NUM_PWM; k++)
    begin
      wval         = next_rand();
      cfg_words[k] = wval[23:0];
      if (k == 0)
        cfg_words[k][23:16] = 8'(PWM_PERIOD - 1);   // dither hits the clip edge
      bus_write(PWM_BASE + 32'(4 * k), {8'h0, cfg_words[k]}, err);
      high_cnt[k] = 0;
    end
    wait_cycles(2 * 16 * PWM_PERIOD);   // settle two full dither cycles
    repeat (16 * PWM_PERIOD)
    begin
      @(posedge adc_clk);
      #1;
      for (int k = 0; k < NUM_PWM; k++)
        high_cnt[k] += int'(dac_pwm_o[k]);
    end
    for (int k = 0; k < NUM_PWM; k++)
      check_value("pwm_high", 32'(pwm_high_count(cfg_words[k], PWM_PERIOD)),
                  32'(high_cnt[k]));

    $display("Done: no errors");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: hw/pitaya_top.sv
//////////////////////////////////////////////////
// single clock; bus comes from pins, region 0 hk, 4 pwm
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pitaya_top #(
  parameter int NUM_PWM    = 4,
  parameter int PWM_PERIOD = 156
) (
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  // system bus
  input  wire logic [pitaya_pkg::BUS_W-1:0] sys_addr_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] sys_wdata_i,
  input  wire logic                         sys_wen_i,
  input  wire logic                         sys_ren_i,
  output logic [pitaya_pkg::BUS_W-1:0]      sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o,
  // converters
  input  wire logic [pitaya_pkg::ADC_W-1:0] adc_dat_a_i,
  input  wire logic [pitaya_pkg::ADC_W-1:0] adc_dat_b_i,
  output logic [pitaya_pkg::ADC_W-1:0]      dac_dat_a_o,
  output logic [pitaya_pkg::ADC_W-1:0]      dac_dat_b_o,
  // slow outputs
  output logic [pitaya_pkg::LED_W-1:0]      led_o,
  output logic [NUM_PWM-1:0]                dac_pwm_o
);

  //////////////////////////////////////////////////
  // bus decode

  logic                         hk_wen, hk_ren, hk_ack, hk_err;
  logic                         pwm_wen, pwm_ren, pwm_ack, pwm_err;
  logic [pitaya_pkg::BUS_W-1:0] hk_rdata;
  logic [pitaya_pkg::BUS_W-1:0] pwm_rdata;

  sys_bus_mux u_sys_bus_mux (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err),
    .pwm_rdata_i (pwm_rdata),
    .pwm_ack_i   (pwm_ack),
    .pwm_err_i   (pwm_err),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .pwm_wen_o   (pwm_wen),
    .pwm_ren_o   (pwm_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  //////////////////////////////////////////////////
  // housekeeping and analog path

  logic                digital_loop;
  pitaya_pkg::sample_t dac_a, dac_b;   // setpoints from hk
  pitaya_pkg::sample_t adc_a, adc_b;   // converted, loopback applied

  hk_regs u_hk_regs (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (hk_wen),
    .sys_ren_i      (hk_ren),
    .adc_a_i        (adc_a),
    .adc_b_i        (adc_b),
    .sys_rdata_o    (hk_rdata),
    .sys_ack_o      (hk_ack),
    .sys_err_o      (hk_err),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .dac_a_o        (dac_a),
    .dac_b_o        (dac_b)
  );

  analog_io u_analog_io (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  //////////////////////////////////////////////////
  // slow PWM DACs

  logic [NUM_PWM-1:0][pitaya_pkg::PWM_CFG_W-1:0] pwm_cfg;

  pwm_cfg_regs #(
    .NUM_PWM (NUM_PWM)
  ) u_pwm_cfg_regs (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (pwm_wen),
    .sys_ren_i   (pwm_ren),
    .sys_rdata_o (pwm_rdata),
    .sys_ack_o   (pwm_ack),
    .sys_err_o   (pwm_err),
    .cfg_o       (pwm_cfg)
  );

  for (genvar g = 0; g < NUM_PWM; g++)
  begin : g_pwm
    pwm_dac #(
      .PWM_PERIOD (PWM_PERIOD)
    ) u_pwm_dac (
      .adc_clk  (adc_clk),
      .arst_n_i (arst_n_i),
      .cfg_i    (pwm_cfg[g]),
      .pwm_o    (dac_pwm_o[g])   // straight to pin
    );
  end

endmodule

`default_nettype wire

// File: hw/pwm_dac.sv
//////////////////////////////////////////////////
// config taken once per period; duty+dither clips at period
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pwm_dac #(
  parameter int PWM_PERIOD = 156
) (
  input  wire logic                             adc_clk,
  input  wire logic                             arst_n_i,
  input  wire logic [pitaya_pkg::PWM_CFG_W-1:0] cfg_i,
  output logic                                  pwm_o
);

  localparam int CNT_W     = $clog2(PWM_PERIOD);
  localparam int DIT_IDX_W = $clog2(pitaya_pkg::PWM_DIT_W);

  logic [CNT_W-1:0]                 cnt_q;       // position in period
  logic [DIT_IDX_W-1:0]             dit_idx_q;   // period number mod 16
  logic [pitaya_pkg::PWM_CFG_W-1:0] cfg_q;       // word for this period
  logic [pitaya_pkg::PWM_DUTY_W:0]  high_len;    // one extra bit for the dither carry
  logic                             period_end;

  assign period_end = cnt_q == CNT_W'(PWM_PERIOD - 1);

  // duty plus this period's dither bit
  assign high_len = {1'b0, cfg_q[pitaya_pkg::PWM_DUTY_LSB +: pitaya_pkg::PWM_DUTY_W]}
                  + {{pitaya_pkg::PWM_DUTY_W{1'b0}}, cfg_q[dit_idx_q]};

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt_q     <= '0;
      dit_idx_q <= '0;
      cfg_q     <= '0;
      pwm_o     <= 1'b0;
    end
    else
    begin
      if (period_end)
      begin
        cnt_q     <= '0;
        dit_idx_q <= dit_idx_q + 1'b1;   // wraps after 16 periods
        cfg_q     <= cfg_i;              // new word from next period on
      end
      else
        cnt_q <= cnt_q + 1'b1;
      // cnt never reaches PWM_PERIOD so long values clip on their own
      pwm_o <= {1'b0, cnt_q} < high_len;
    end
  end

  a_cnt_range: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    cnt_q < PWM_PERIOD);

endmodule

`default_nettype wire

// File: hw/pwm_cfg_regs.sv
//////////////////////////////////////////////////
// one word per channel, upper 8 data bits dropped
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pwm_cfg_regs #(
  parameter int NUM_PWM = 4
) (
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] sys_addr_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] sys_wdata_i,
  input  wire logic                         sys_wen_i,
  input  wire logic                         sys_ren_i,
  output logic [pitaya_pkg::BUS_W-1:0]      sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o,
  output logic [NUM_PWM-1:0][pitaya_pkg::PWM_CFG_W-1:0] cfg_o
);

  localparam int IDX_W = pitaya_pkg::REG_OFS_W - pitaya_pkg::PWM_OFS_LSB;

  logic [IDX_W-1:0] idx;   // channel number from offset
  logic             hit;   // channel exists

  assign idx = sys_addr_i[pitaya_pkg::REG_OFS_W-1:pitaya_pkg::PWM_OFS_LSB];
  assign hit = idx < NUM_PWM;

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
      cfg_o       <= '0;   // duty 0, outputs stay low
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~hit;
      if (sys_ren_i && hit)
        sys_rdata_o <= {{(pitaya_pkg::BUS_W-pitaya_pkg::PWM_CFG_W){1'b0}}, cfg_o[idx]};
      else
        sys_rdata_o <= '0;
      if (sys_wen_i && hit)
        cfg_o[idx] <= sys_wdata_i[pitaya_pkg::PWM_CFG_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/analog_io.sv
//////////////////////////////////////////////////
// converter pins use negative slope offset binary
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module analog_io (
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  input  wire logic [pitaya_pkg::ADC_W-1:0] adc_dat_a_i,
  input  wire logic [pitaya_pkg::ADC_W-1:0] adc_dat_b_i,
  input  wire logic                         digital_loop_i,
  input  wire pitaya_pkg::sample_t          dac_a_i,
  input  wire pitaya_pkg::sample_t          dac_b_i,
  output pitaya_pkg::sample_t               adc_a_o,
  output pitaya_pkg::sample_t               adc_b_o,
  output logic [pitaya_pkg::ADC_W-1:0]      dac_dat_a_o,
  output logic [pitaya_pkg::ADC_W-1:0]      dac_dat_b_o
);

  logic [pitaya_pkg::ADC_W-1:0] adc_raw_a;   // pin capture
  logic [pitaya_pkg::ADC_W-1:0] adc_raw_b;

  // keep msb, invert the rest; same map both directions
  function automatic logic [pitaya_pkg::ADC_W-1:0] slope_flip(
    input logic [pitaya_pkg::ADC_W-1:0] x
  );
    return {x[pitaya_pkg::ADC_W-1], ~x[pitaya_pkg::ADC_W-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // ADC side

  always_ff @(posedge adc_clk)
  begin
    adc_raw_a <= adc_dat_a_i;
    adc_raw_b <= adc_dat_b_i;
  end

  // loopback bypasses the converter
  assign adc_a_o = digital_loop_i ? dac_a_i : slope_flip(adc_raw_a);
  assign adc_b_o = digital_loop_i ? dac_b_i : slope_flip(adc_raw_b);

  //////////////////////////////////////////////////
  // DAC side

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= {1'b0, {(pitaya_pkg::ADC_W-1){1'b1}}};  // code of zero
      dac_dat_b_o <= {1'b0, {(pitaya_pkg::ADC_W-1){1'b1}}};
    end
    else
    begin
      dac_dat_a_o <= slope_flip(dac_a_i);
      dac_dat_b_o <= slope_flip(dac_b_i);
    end
  end

endmodule

`default_nettype wire

// File: hw/hk_regs.sv
//////////////////////////////////////////////////
// full word writes, ADC readback is live and read only
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module hk_regs (
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] sys_addr_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] sys_wdata_i,
  input  wire logic                         sys_wen_i,
  input  wire logic                         sys_ren_i,
  input  wire pitaya_pkg::sample_t          adc_a_i,
  input  wire pitaya_pkg::sample_t          adc_b_i,
  output logic [pitaya_pkg::BUS_W-1:0]      sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o,
  output logic                              digital_loop_o,
  output logic [pitaya_pkg::LED_W-1:0]      led_o,
  output pitaya_pkg::sample_t               dac_a_o,
  output pitaya_pkg::sample_t               dac_b_o
);

  logic [pitaya_pkg::REG_OFS_W-1:0] ofs;
  logic [pitaya_pkg::BUS_W-1:0]     rd_word;
  logic                             rd_ok;    // offset exists
  logic                             wr_ok;    // offset exists and is writable

  // signed sample to bus word
  function automatic logic [pitaya_pkg::BUS_W-1:0] sext(input pitaya_pkg::sample_t s);
    return {{(pitaya_pkg::BUS_W-pitaya_pkg::ADC_W){s[pitaya_pkg::ADC_W-1]}}, s};
  endfunction

  assign ofs = sys_addr_i[pitaya_pkg::REG_OFS_W-1:0];

  //////////////////////////////////////////////////
  // offset decode

  always_comb
  begin
    rd_word = '0;
    rd_ok   = 1'b1;
    wr_ok   = 1'b0;
    case (ofs)
      pitaya_pkg::HK_OFS_ID:    rd_word = pitaya_pkg::HK_ID;
      pitaya_pkg::HK_OFS_LOOP:
      begin
        rd_word[0] = digital_loop_o;
        wr_ok      = 1'b1;
      end
      pitaya_pkg::HK_OFS_LED:
      begin
        rd_word[pitaya_pkg::LED_W-1:0] = led_o;
        wr_ok                          = 1'b1;
      end
      pitaya_pkg::HK_OFS_DAC_A:
      begin
        rd_word = sext(dac_a_o);
        wr_ok   = 1'b1;
      end
      pitaya_pkg::HK_OFS_DAC_B:
      begin
        rd_word = sext(dac_b_o);
        wr_ok   = 1'b1;
      end
      pitaya_pkg::HK_OFS_ADC_A: rd_word = sext(adc_a_i);   // live sample
      pitaya_pkg::HK_OFS_ADC_B: rd_word = sext(adc_b_i);
      default:                  rd_ok   = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // registers and registered response

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sys_ack_o      <= 1'b0;
      sys_err_o      <= 1'b0;
      sys_rdata_o    <= '0;
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      dac_a_o        <= '0;   // DAC pins idle at mid code
      dac_b_o        <= '0;
    end
    else
    begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_err_o   <= (sys_ren_i & ~rd_ok) | (sys_wen_i & ~wr_ok);
      sys_rdata_o <= (sys_ren_i && rd_ok) ? rd_word : '0;
      if (sys_wen_i && wr_ok)
      begin
        case (ofs)
          pitaya_pkg::HK_OFS_LOOP:  digital_loop_o <= sys_wdata_i[0];
          pitaya_pkg::HK_OFS_LED:   led_o   <= sys_wdata_i[pitaya_pkg::LED_W-1:0];
          pitaya_pkg::HK_OFS_DAC_A: dac_a_o <= sys_wdata_i[pitaya_pkg::ADC_W-1:0];
          default:                  dac_b_o <= sys_wdata_i[pitaya_pkg::ADC_W-1:0];
        endcase
      end
    end
  end

  // master waits for ack, so never back to back
  a_ack_pulse: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    sys_ack_o |=> !sys_ack_o);

endmodule

`default_nettype wire

// File: hw/sys_bus_mux.sv
//////////////////////////////////////////////////
// one outstanding request, slaves ack one cycle later
// unmapped regions ack with zero data and no error
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sys_bus_mux (
  input  wire logic                         adc_clk,
  input  wire logic                         arst_n_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] sys_addr_i,
  input  wire logic                         sys_wen_i,
  input  wire logic                         sys_ren_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] hk_rdata_i,
  input  wire logic                         hk_ack_i,
  input  wire logic                         hk_err_i,
  input  wire logic [pitaya_pkg::BUS_W-1:0] pwm_rdata_i,
  input  wire logic                         pwm_ack_i,
  input  wire logic                         pwm_err_i,
  output logic                              hk_wen_o,
  output logic                              hk_ren_o,
  output logic                              pwm_wen_o,
  output logic                              pwm_ren_o,
  output logic [pitaya_pkg::BUS_W-1:0]      sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o
);

  logic [pitaya_pkg::REGION_W-1:0]    region;
  logic [pitaya_pkg::REGION_W-1:0]    region_q;     // region of pending request
  logic [pitaya_pkg::NUM_REGIONS-1:0] cs;           // one-hot chip select
  logic                               req;
  logic                               mapped;
  logic                               unmap_ack_q;

  assign region = sys_addr_i[pitaya_pkg::REGION_LSB +: pitaya_pkg::REGION_W];
  assign cs     = {{(pitaya_pkg::NUM_REGIONS-1){1'b0}}, 1'b1} << region;
  assign req    = sys_wen_i | sys_ren_i;
  assign mapped = cs[pitaya_pkg::HK_REGION] | cs[pitaya_pkg::PWM_REGION];

  assign hk_wen_o  = sys_wen_i & cs[pitaya_pkg::HK_REGION];
  assign hk_ren_o  = sys_ren_i & cs[pitaya_pkg::HK_REGION];
  assign pwm_wen_o = sys_wen_i & cs[pitaya_pkg::PWM_REGION];
  assign pwm_ren_o = sys_ren_i & cs[pitaya_pkg::PWM_REGION];

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      region_q    <= '0;
      unmap_ack_q <= 1'b0;
    end
    else
    begin
      unmap_ack_q <= req & ~mapped;  // stand-in slave for empty regions
      if (req)
        region_q <= region;          // addr may move before the ack
    end
  end

  // response select by the region that was requested
  always_comb
  begin
    case (region_q)
      pitaya_pkg::HK_REGION:
      begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
        sys_err_o   = hk_err_i;
      end
      pitaya_pkg::PWM_REGION:
      begin
        sys_rdata_o = pwm_rdata_i;
        sys_ack_o   = pwm_ack_i;
        sys_err_o   = pwm_err_i;
      end
      default:
      begin
        sys_rdata_o = '0;
        sys_ack_o   = unmap_ack_q;
        sys_err_o   = 1'b0;
      end
    endcase
  end

  a_single_dir: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(sys_wen_i && sys_ren_i));

endmodule

`default_nettype wire

// File: hw/pitaya_pkg.sv
//////////////////////////////////////////////////
// one clock domain, full word bus writes only
// offsets decoded in low REG_OFS_W bits of a region
//////////////////////////////////////////////////
`default_nettype none

package pitaya_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int ADC_W     = 14;   // sample width, reserved low bits dropped
  localparam int BUS_W     = 32;   // bus addr and data
  localparam int LED_W     = 8;
  localparam int PWM_CFG_W = 24;

  typedef logic signed [ADC_W-1:0] sample_t;

  //////////////////////////////////////////////////
  // address map

  localparam int REGION_LSB  = 20;  // addr[22:20] picks the region
  localparam int REGION_W    = 3;
  localparam int NUM_REGIONS = 8;
  localparam int REG_OFS_W   = 8;   // decoded offset bits inside a region

  localparam int HK_REGION  = 0;
  localparam int PWM_REGION = 4;

  // housekeeping offsets
  localparam logic [REG_OFS_W-1:0] HK_OFS_ID    = 8'h00;
  localparam logic [REG_OFS_W-1:0] HK_OFS_LOOP  = 8'h04;
  localparam logic [REG_OFS_W-1:0] HK_OFS_LED   = 8'h08;
  localparam logic [REG_OFS_W-1:0] HK_OFS_DAC_A = 8'h0C;
  localparam logic [REG_OFS_W-1:0] HK_OFS_DAC_B = 8'h10;
  localparam logic [REG_OFS_W-1:0] HK_OFS_ADC_A = 8'h14;  // read only
  localparam logic [REG_OFS_W-1:0] HK_OFS_ADC_B = 8'h18;  // read only

  localparam logic [BUS_W-1:0] HK_ID = 32'h5049_0001;

  //////////////////////////////////////////////////
  // pwm config word, channel k at offset 4*k

  localparam int PWM_OFS_LSB  = 2;   // word index starts here
  localparam int PWM_DUTY_LSB = 16;  // duty in [23:16]
  localparam int PWM_DUTY_W   = 8;
  localparam int PWM_DIT_W    = 16;  // dither sequence in [15:0]

endpackage

`default_nettype wire
